//--- Bender.yml
package:
  name: overlay

sources:
  - files:
      - logic/vid_geom_pkg.sv
      - logic/bmp_fmt_pkg.sv
      - logic/font_rom.sv
      - logic/image_rom.sv
      - logic/bmp_placer.sv
      - logic/video_mem.sv
      - logic/overlay_top.sv
  - target: simulation
    files:
      - bench/overlay_chk.sv
      - bench/overlay_tb.sv

//--- bench/overlay_chk.sv
`timescale 1ns/100ps

module overlay_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 we,
  input logic                 busy,
  input logic                 rem_q,  // latched erase flag
  input bmp_fmt_pkg::pix_t    wdata,
  input vid_geom_pkg::vaddr_t waddr
);
  import vid_geom_pkg::*;
  import bmp_fmt_pkg::*;

  int fail_cnt = 0;  // assertion failures seen

  ////////////////////////////////////////////////////////////
  // write port rules
  ////////////////////////////////////////////////////////////
  // writes only inside a command
  we_in_cmd: assert property (@(posedge clk) disable iff (!rst_n) we |-> busy)
    else begin
      fail_cnt++;
      $error("video write while placer idle");
    end

  // transparent code never lands in the frame on an add
  no_transp: assert property (@(posedge clk) disable iff (!rst_n)
                              (we && !rem_q) |-> (wdata != pix_transp))
    else begin
      fail_cnt++;
      $error("transparent pixel written, wdata %h", wdata);
    end

  wa_range: assert property (@(posedge clk) disable iff (!rst_n)
                             we |-> (waddr < vaddr_t'(scr_pix)))  // inside 640x480
    else begin
      fail_cnt++;
      $error("write address %h past the frame", waddr);
    end

endmodule

bind bmp_placer overlay_chk chk_inst (
  .clk   (clk),
  .rst_n (rst_n),
  .we    (we),
  .busy  (busy),
  .rem_q (rem_q),
  .wdata (wdata),
  .waddr (waddr)
);

//--- bench/overlay_tb.sv
`timescale 1ns/100ps

module overlay_tb;
  import vid_geom_pkg::*;
  import bmp_fmt_pkg::*;

  localparam int clk_per     = 100;   // ns
  localparam int rst_cyc     = 16;
  localparam int max_rec     = 64;    // vector records of four words
  localparam int max_cmd_cyc = 1000;  // longest command plus its sweeps

  logic     clk;
  logic     rst_n;
  logic     add_img;
  logic     rem_img;
  logic     add_fnt;
  img_idx_t image_indx;
  glyph_t   fnt_indx;
  xloc_t    xloc;
  yloc_t    yloc;
  logic     busy;
  vaddr_t   rd_addr;
  pix_t     rd_data;

  logic [19:0] vec [4*max_rec];  // kind, idx or expected, x or address, y
  pix_t        shadow [scr_pix];  // model of the frame buffer
  int          n_rec;
  logic [31:0] lfsr_q;

  overlay_top overlay_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .add_img    (add_img),
    .rem_img    (rem_img),
    .add_fnt    (add_fnt),
    .image_indx (image_indx),
    .fnt_indx   (fnt_indx),
    .xloc       (xloc),
    .yloc       (yloc),
    .busy       (busy),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_per / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // content rules of the bitmap sources
  ////////////////////////////////////////////////////////////
  function automatic int img_width(input int k);
    return 8 + 4 * k;
  endfunction

  function automatic int img_height(input int k);
    return 5 + k;
  endfunction

  function automatic pix_t img_word(input int k, input int n);
    return pix_t'((7 * k + 3 * n) % 64);  // pixel n of image k
  endfunction

  function automatic pix_t font_word(input int a);
    return pix_t'((5 * a + 1) % 64);  // sheet word a
  endfunction

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////
  task automatic fail_stop();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  // one read per cycle with the address set on the falling edge
  task automatic read_pix(input int addr, output pix_t data);
    rd_addr = vaddr_t'(addr);
    @(negedge clk);
    data = rd_data;  // registered one rising edge ago
  endtask

  // bitmap rectangle plus a one pixel border checked against the model
  task automatic sweep_rect(input int x0, input int y0, input int w, input int h);
    int   xa;
    int   xb;
    int   ya;
    int   yb;
    int   addr;
    pix_t got;
    xa = (x0 > 0) ? x0 - 1 : 0;
    ya = (y0 > 0) ? y0 - 1 : 0;
    xb = (x0 + w < scr_w) ? x0 + w : scr_w - 1;
    yb = (y0 + h < scr_h) ? y0 + h : scr_h - 1;
    for (int y = ya; y <= yb; y++) begin
      for (int x = xa; x <= xb; x++) begin
        addr = y * scr_w + x;
        read_pix(addr, got);
        check_eq($sformatf("rd_data[%0h]", addr), got, shadow[addr]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // model updates
  ////////////////////////////////////////////////////////////
  task automatic shadow_image(input int k, input int x, input int y, input bit erase);
    pix_t p;
    for (int r = 0; r < img_height(k); r++) begin
      for (int c = 0; c < img_width(k); c++) begin
        p = img_word(k, r * img_width(k) + c);
        if (p != 6'h24)
          shadow[(y + r) * scr_w + x + c] = erase ? '0 : p;  // erase only opaque spots
      end
    end
  endtask

  task automatic shadow_glyph(input int g, input int x, input int y);
    pix_t p;
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 13; c++) begin
        p = font_word(546 * r + 13 * g + c);  // glyphs sit side by side on the sheet
        if (p != 6'h24)
          shadow[(y + r) * scr_w + x + c] = p;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // commands
  ////////////////////////////////////////////////////////////
  // op 1 add image, 2 remove image, 3 add glyph
  task automatic issue_cmd(input int op, input int idx, input int x, input int y,
                           input bit hammer);
    logic [31:0] r;
    add_img    = (op == 1);
    rem_img    = (op == 2);
    add_fnt    = (op == 3);
    image_indx = img_idx_t'(idx);
    fnt_indx   = glyph_t'(idx);
    xloc       = xloc_t'(x);
    yloc       = yloc_t'(y);
    @(negedge clk);
    add_img = 1'b0;
    rem_img = 1'b0;
    add_fnt = 1'b0;
    check_eq("busy", busy, 1);
    while (busy) begin
      if (hammer) begin  // decoys aimed at the origin that must all be dropped
        take_bits(2, r);
        add_img    = (r[1:0] == 2'd0) || (r[1:0] == 2'd3);
        rem_img    = (r[1:0] == 2'd1);
        add_fnt    = (r[1:0] >= 2'd2);
        take_bits(2, r);
        image_indx = img_idx_t'(r);
        take_bits(5, r);
        fnt_indx   = glyph_t'(r);
        xloc       = '0;
        yloc       = '0;
      end
      @(negedge clk);
    end
    add_img = 1'b0;  // idle now so nothing may be sampled
    rem_img = 1'b0;
    add_fnt = 1'b0;
  endtask

  task automatic run_cmd(input int op, input int idx, input int x, input int y,
                         input bit hammer);
    int w;
    int h;
    issue_cmd(op, idx, x, y, hammer);
    if (op == 3) begin
      shadow_glyph(idx, x, y);
      w = 13;
      h = 16;
    end else begin
      shadow_image(idx, x, y, op == 2);
      w = img_width(idx);
      h = img_height(idx);
    end
    sweep_rect(x, y, w, h);
    if (hammer)
      sweep_rect(0, 0, 20, 16);  // largest decoy footprint
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int   kind;
    int   a;
    int   b;
    int   c;
    int   n;
    pix_t got;
    rst_n      = 1'b0;
    add_img    = 1'b0;
    rem_img    = 1'b0;
    add_fnt    = 1'b0;
    image_indx = '0;
    fnt_indx   = '0;
    xloc       = '0;
    yloc       = '0;
    rd_addr    = '0;
    n_rec      = 0;
    lfsr_q     = 32'h6014_a093;
    for (int i = 0; i < scr_pix; i++) begin
      shadow[i] = '0;
    end
    for (int i = 0; i < 4 * max_rec; i++) begin
      vec[i] = '0;  // kind 0 ends the list
    end
    $readmemh("bench/overlay_vectors.hex", vec);
    n = 0;
    while (n < max_rec && vec[4*n] != 0) n++;
    n_rec = n;

    repeat (rst_cyc) @(negedge clk);
    rst_n = 1'b1;
    check_eq("busy", busy, 0);

    for (int i = 0; i < n_rec; i++) begin
      kind = int'(vec[4*i]);
      a    = int'(vec[4*i+1]);
      b    = int'(vec[4*i+2]);
      c    = int'(vec[4*i+3]);
      if (kind == 4) begin  // probe record with b as frame address
        read_pix(b, got);
        check_eq($sformatf("rd_data[%0h]", b), got, a);
        check_eq($sformatf("rd_data[%0h]", b), got, shadow[b]);
      end else if ((kind & 7) >= 1 && (kind & 7) <= 3) begin
        run_cmd(kind & 7, a, b, c, kind[3]);
      end else begin
        $display("unknown record kind %0d in vector record %0d", kind, i);
        fail_stop();
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

  // bound assertions on the placer count their failures
  initial begin
    wait (overlay_top_inst.placer_inst.chk_inst.fail_cnt != 0);
    $display("an assertion on the placer outputs failed at %0t ns", $time);
    fail_stop();
  end

  // watchdog budget grows with the number of records
  initial begin
    int limit_ns;
    wait (n_rec > 0);
    limit_ns = 2 * (rst_cyc + n_rec * max_cmd_cyc) * clk_per;
    #(limit_ns);
    $display("timeout, busy never fell within %0d ns", limit_ns);
    fail_stop();
  end

endmodule

//--- bench/overlay_vectors.hex
// kind idx x y : kind 1 add image, 2 remove image, 3 add glyph, bit 3 adds strobes while busy
// kind 4 probe : 4 expected_pixel frame_address 0, kind 0 ends the list
4 00 00000 0
4 00 12345 0
4 00 4AFFF 0
1 01 00064 032
4 07 07D64 0
4 28 07D6F 0
4 00 07D70 0
4 00 0826B 0
4 1C 089EF 0
3 11 0012C 0C8
4 12 1F52C 0
4 04 21AB8 0
4 00 1F7B4 0
4 00 1F539 0
3 05 00068 030
4 3D 0826B 0
4 19 07D6A 0
4 1A 07D68 0
2 01 00064 032
4 3D 0826B 0
4 00 07D6A 0
4 00 07D68 0
4 00 07D64 0
4 06 07868 0
B 00 00028 190
4 01 3E828 0
4 00 00000 0
1 03 00258 00A
4 15 01B58 0
4 00 01B5D 0
4 11 01DD8 0
4 32 02CEB 0
4 00 01B6C 0
1 02 0026C 00C
4 0E 0206C 0
4 1B 02F7B 0
4 00 02F7C 0
4 06 0206B 0
0 00 00000 0

//--- logic/bmp_fmt_pkg.sv
package bmp_fmt_pkg;

  ////////////////////////////////////////////////////////////
  // pixels
  ////////////////////////////////////////////////////////////
  localparam int pix_w = 6;
  typedef logic [pix_w-1:0] pix_t;
  localparam pix_t pix_transp = 6'h24;  // never written to video memory

  ////////////////////////////////////////////////////////////
  // font sheet
  ////////////////////////////////////////////////////////////
  localparam int fnt_w       = 13;                   // columns per glyph
  localparam int fnt_h       = 16;                   // rows per glyph
  localparam int fnt_cnt     = 42;                   // 0-9 A-Z and six symbols
  localparam int fnt_sheet_w = fnt_w * fnt_cnt;      // 546 columns in the whole sheet
  localparam int fnt_words   = fnt_sheet_w * fnt_h;  // 8736
  localparam int fnt_pix_a   = 5;                    // sheet word a = 5a + 1
  localparam int fnt_pix_c   = 1;
  typedef logic [13:0] faddr_t;
  typedef logic [5:0]  glyph_t;

  ////////////////////////////////////////////////////////////
  // image store
  ////////////////////////////////////////////////////////////
  localparam int img_cnt       = 4;
  localparam int img_words     = 1024;                // one slot per image
  localparam int img_sel_w     = $clog2(img_cnt);     // 2
  localparam int img_ofs_w     = $clog2(img_words);   // 10
  localparam int img_hdr_words = 4;                   // wid hi, wid lo, hgt hi, hgt lo
  localparam int img_w0        = 8;                   // image k is 8+4k wide
  localparam int img_w_step    = 4;
  localparam int img_h0        = 5;                   // and 5+k high
  localparam int img_h_step    = 1;
  localparam int img_pix_k     = 7;                   // pixel n of image k = 7k + 3n
  localparam int img_pix_n     = 3;
  typedef logic [img_sel_w+img_ofs_w-1:0] iaddr_t;    // {image, offset}
  typedef logic [5:0]  img_idx_t;
  typedef logic [15:0] bmp_ofs_t;

endpackage

//--- logic/bmp_placer.sv
`timescale 1ns/100ps

module bmp_placer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  add_img,     // strobe, draw image
  input  logic                  rem_img,     // strobe, erase image
  input  logic                  add_fnt,     // strobe, draw glyph
  input  bmp_fmt_pkg::img_idx_t image_indx,
  input  bmp_fmt_pkg::glyph_t   fnt_indx,    // one of 42
  input  vid_geom_pkg::xloc_t   xloc,        // upper left column
  input  vid_geom_pkg::yloc_t   yloc,        // upper left row
  input  bmp_fmt_pkg::pix_t     font_data,   // one cycle after font_addr
  input  bmp_fmt_pkg::pix_t     image_data,  // one cycle after image_addr
  output bmp_fmt_pkg::faddr_t   font_addr,
  output bmp_fmt_pkg::iaddr_t   image_addr,
  output vid_geom_pkg::vaddr_t  waddr,
  output bmp_fmt_pkg::pix_t     wdata,
  output logic                  we,
  output logic                  busy         // level, strobes dropped while high
);
  import vid_geom_pkg::*;
  import bmp_fmt_pkg::*;

  typedef enum logic [3:0] {
    idle,
    adv_img,  // put header word 0 on the rom
    hdr_xh,
    hdr_xl,
    hdr_yh,
    hdr_yl,
    wr_img,   // one pixel per cycle
    adv_fnt,  // put row start on the rom
    wr_fnt
  } state_t;

  state_t state;
  state_t nxt_state;

  // latched command
  logic     fnt_cmd;  // listen to font rom
  logic     rem_q;    // erase instead of draw
  img_idx_t img_q;

  // image walk
  bmp_ofs_t bmp_ofs;     // rom offset inside the slot
  bmp_ofs_t ofs_end;     // first offset past the last pixel plus latency
  xloc_t    xwid;
  yloc_t    yhgt;        // high part only
  yloc_t    yhgt_full;
  vaddr_t   waddr_wrap;  // last column of current row

  // glyph walk
  faddr_t     faddr;
  logic [3:0] col_cnt;  // writes done in this row
  logic [3:0] row_cnt;

  pix_t src_pix;
  logic opaque;

  // fsm strobes
  logic cap_cmd;
  logic ld_xh;
  logic ld_xl;
  logic ld_yh;
  logic ld_yl;
  logic ofs_inc;
  logic fnt_inc;
  logic col_inc;
  logic fnt_row;  // row end of a glyph
  logic wa_inc;
  logic wa_wrap;  // row end of an image

  assign src_pix   = fnt_cmd ? font_data : image_data;
  assign opaque    = (src_pix != pix_transp);
  assign yhgt_full = yhgt + yloc_t'(src_pix);

  assign font_addr  = faddr;
  assign image_addr = {img_q[img_sel_w-1:0], bmp_ofs[img_ofs_w-1:0]};

  ////////////////////////////////////////////////////////////
  // command capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fnt_cmd <= 1'b0;
      rem_q   <= 1'b0;
    end else if (cap_cmd) begin
      fnt_cmd <= !(add_img || rem_img);  // image strobe wins
      rem_q   <= rem_img;
    end
  end

  // header fields and image number
  always_ff @(posedge clk) begin
    if (cap_cmd)
      img_q <= image_indx;
    if (ld_xh)
      xwid <= xloc_t'(src_pix) << pix_w;
    else if (ld_xl)
      xwid <= xwid + xloc_t'(src_pix);
    if (ld_yh)
      yhgt <= yloc_t'(src_pix) << pix_w;
    // header words plus one cycle of rom latency
    if (ld_yl)
      ofs_end <= bmp_ofs_t'(xwid) * bmp_ofs_t'(yhgt_full) + bmp_ofs_t'(img_hdr_words + 1);
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bmp_ofs <= '0;
    else if (cap_cmd)
      bmp_ofs <= '0;
    else if (ofs_inc)
      bmp_ofs <= bmp_ofs + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // video memory address
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      waddr_wrap <= '0;
    else if (ld_yh)
      waddr_wrap <= waddr + vaddr_t'(xwid) - 1'b1;  // xwid complete here
    else if (wa_wrap)
      waddr_wrap <= waddr_wrap + vaddr_t'(scr_w);
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      waddr <= '0;
    else if (cap_cmd)
      waddr <= vaddr_t'(yloc) * vaddr_t'(scr_w) + vaddr_t'(xloc);
    else if (wa_wrap)
      waddr <= waddr + vaddr_t'(scr_w + 1) - vaddr_t'(xwid);  // start of next row
    else if (fnt_row)
      waddr <= waddr + vaddr_t'(scr_w - fnt_w);
    else if (wa_inc)
      waddr <= waddr + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // glyph sheet walk
  ////////////////////////////////////////////////////////////
  // faddr runs one word ahead of the data and one more at row end
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      faddr <= '0;
    else if (cap_cmd)
      faddr <= faddr_t'(fnt_w * fnt_indx);
    else if (fnt_row)
      faddr <= faddr + faddr_t'(fnt_sheet_w - fnt_w - 1);
    else if (fnt_inc)
      faddr <= faddr + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (cap_cmd) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (fnt_row) begin
      col_cnt <= '0;
      row_cnt <= row_cnt + 1'b1;
    end else if (col_inc) begin
      col_cnt <= col_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= idle;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    cap_cmd   = 1'b0;
    ld_xh     = 1'b0;
    ld_xl     = 1'b0;
    ld_yh     = 1'b0;
    ld_yl     = 1'b0;
    ofs_inc   = 1'b0;
    fnt_inc   = 1'b0;
    col_inc   = 1'b0;
    fnt_row   = 1'b0;
    wa_inc    = 1'b0;
    wa_wrap   = 1'b0;
    we        = 1'b0;
    wdata     = '0;
    busy      = 1'b1;  // low only in idle

    case (state)
      idle: begin
        busy = 1'b0;
        if (add_img || rem_img) begin
          cap_cmd   = 1'b1;
          nxt_state = adv_img;
        end else if (add_fnt) begin
          cap_cmd   = 1'b1;
          nxt_state = adv_fnt;
        end
      end
      adv_img: begin
        ofs_inc   = 1'b1;
        nxt_state = hdr_xh;
      end
      hdr_xh: begin
        ld_xh     = 1'b1;
        ofs_inc   = 1'b1;
        nxt_state = hdr_xl;
      end
      hdr_xl: begin
        ld_xl     = 1'b1;
        ofs_inc   = 1'b1;
        nxt_state = hdr_yh;
      end
      hdr_yh: begin
        ld_yh     = 1'b1;
        ofs_inc   = 1'b1;
        nxt_state = hdr_yl;
      end
      hdr_yl: begin
        ld_yl     = 1'b1;
        ofs_inc   = 1'b1;  // pixel 0 on the rom
        nxt_state = wr_img;
      end
      wr_img: begin
        if (bmp_ofs < ofs_end) begin
          ofs_inc = 1'b1;
          wa_inc  = 1'b1;
          wa_wrap = (waddr == waddr_wrap);
          we      = opaque;                   // transparent skipped, address still moves
          wdata   = rem_q ? '0 : src_pix;     // erase clears opaque spots only
        end else begin
          nxt_state = idle;
        end
      end
      adv_fnt: begin
        fnt_inc   = 1'b1;
        nxt_state = wr_fnt;
      end
      wr_fnt: begin
        if (col_cnt == 4'(fnt_w)) begin
          fnt_row   = 1'b1;
          nxt_state = (row_cnt == 4'(fnt_h - 1)) ? idle : adv_fnt;
        end else begin
          fnt_inc = 1'b1;
          col_inc = 1'b1;
          wa_inc  = 1'b1;
          we      = opaque;
          wdata   = src_pix;
        end
      end
      default: nxt_state = idle;
    endcase
  end

endmodule

//--- logic/font_rom.sv
`timescale 1ns/100ps

module font_rom (
  input  logic                clk,
  input  bmp_fmt_pkg::faddr_t addr,
  output bmp_fmt_pkg::pix_t   dout
);
  import bmp_fmt_pkg::*;

  // 546 x 16 sheet stored row-major
  // glyph g row r starts at word 546r + 13g
  pix_t sheet [fnt_words];

  ////////////////////////////////////////////////////////////
  // sheet contents
  ////////////////////////////////////////////////////////////
  initial begin
    for (int a = 0; a < fnt_words; a++) begin
      sheet[a] = pix_t'(fnt_pix_a * a + fnt_pix_c);  // mod 64 by truncation
    end
  end

  // registered read
  // the placer runs one word past the last sheet row at a row end
  always_ff @(posedge clk) begin
    if (addr < faddr_t'(fnt_words))
      dout <= sheet[addr];
    else
      dout <= '0;  // off the sheet
  end

endmodule

//--- logic/image_rom.sv
`timescale 1ns/100ps

module image_rom (
  input  logic                clk,
  input  bmp_fmt_pkg::iaddr_t addr,  // {image number, offset in slot}
  output bmp_fmt_pkg::pix_t   dout
);
  import bmp_fmt_pkg::*;

  pix_t slots [img_cnt * img_words];  // four slots of 1024 words

  ////////////////////////////////////////////////////////////
  // slot contents
  ////////////////////////////////////////////////////////////
  // words 0..3 hold the header in 6-bit pieces
  // pixel n sits at slot word n + 4
  initial begin
    int w;     // width of image k
    int h;     // height of image k
    int base;  // first word of slot k
    for (int k = 0; k < img_cnt; k++) begin
      w    = img_w0 + img_w_step * k;
      h    = img_h0 + img_h_step * k;
      base = k * img_words;
      slots[base]     = pix_t'(w >> pix_w);  // width high bits
      slots[base + 1] = pix_t'(w);           // width low six bits
      slots[base + 2] = pix_t'(h >> pix_w);
      slots[base + 3] = pix_t'(h);
      // pixel rule runs to the end of the slot
      for (int j = img_hdr_words; j < img_words; j++) begin
        slots[base + j] = pix_t'(img_pix_k * k + img_pix_n * (j - img_hdr_words));
      end
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    dout <= slots[addr];
  end

endmodule

//--- logic/overlay_top.sv
`timescale 1ns/100ps

module overlay_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  add_img,
  input  logic                  rem_img,
  input  logic                  add_fnt,
  input  bmp_fmt_pkg::img_idx_t image_indx,
  input  bmp_fmt_pkg::glyph_t   fnt_indx,
  input  vid_geom_pkg::xloc_t   xloc,
  input  vid_geom_pkg::yloc_t   yloc,
  output logic                  busy,
  input  vid_geom_pkg::vaddr_t  rd_addr,
  output bmp_fmt_pkg::pix_t     rd_data
);
  import vid_geom_pkg::*;
  import bmp_fmt_pkg::*;

  faddr_t font_addr;
  iaddr_t image_addr;
  pix_t   font_data;
  pix_t   image_data;
  vaddr_t waddr;      // placer to frame buffer
  pix_t   wdata;
  logic   we;

  // command engine
  bmp_placer placer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .add_img    (add_img),
    .rem_img    (rem_img),
    .add_fnt    (add_fnt),
    .image_indx (image_indx),
    .fnt_indx   (fnt_indx),
    .xloc       (xloc),
    .yloc       (yloc),
    .font_data  (font_data),
    .image_data (image_data),
    .font_addr  (font_addr),
    .image_addr (image_addr),
    .waddr      (waddr),
    .wdata      (wdata),
    .we         (we),
    .busy       (busy)
  );

  ////////////////////////////////////////////////////////////
  // bitmap sources
  ////////////////////////////////////////////////////////////
  font_rom font_rom_inst (
    .clk  (clk),
    .addr (font_addr),
    .dout (font_data)
  );

  image_rom image_rom_inst (
    .clk  (clk),
    .addr (image_addr),
    .dout (image_data)
  );

  // frame buffer with observation port
  video_mem video_mem_inst (
    .clk     (clk),
    .we      (we),
    .waddr   (waddr),
    .wdata   (wdata),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- logic/vid_geom_pkg.sv
package vid_geom_pkg;

  ////////////////////////////////////////////////////////////
  // visible frame
  ////////////////////////////////////////////////////////////
  localparam int scr_w   = 640;            // columns per row
  localparam int scr_h   = 480;            // rows per frame
  localparam int scr_pix = scr_w * scr_h;  // 307200 locations

  // field widths derived from the frame size
  localparam int vaddr_w = $clog2(scr_pix);  // 19 bits
  localparam int xloc_w  = $clog2(scr_w);    // 10 bits
  localparam int yloc_w  = $clog2(scr_h);    // 9 bits

  ////////////////////////////////////////////////////////////
  // address and coordinate types
  ////////////////////////////////////////////////////////////

  // linear frame buffer address
  // row * scr_w + column
  typedef logic [vaddr_w-1:0] vaddr_t;

  typedef logic [xloc_w-1:0] xloc_t;  // column 0..639
  typedef logic [yloc_w-1:0] yloc_t;  // row 0..479

endpackage

//--- logic/video_mem.sv
`timescale 1ns/100ps

module video_mem (
  input  logic                 clk,
  input  logic                 we,
  input  vid_geom_pkg::vaddr_t waddr,
  input  bmp_fmt_pkg::pix_t    wdata,
  input  vid_geom_pkg::vaddr_t rd_addr,
  output bmp_fmt_pkg::pix_t    rd_data  // one cycle after rd_addr
);
  import vid_geom_pkg::*;

  bmp_fmt_pkg::pix_t frame [scr_pix];  // one word per screen location

  // blank screen at power up
  initial begin
    for (int i = 0; i < scr_pix; i++) begin
      frame[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (we)
      frame[waddr] <= wdata;
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////
  // same-address read during a write returns the old word
  always_ff @(posedge clk) begin
    rd_data <= frame[rd_addr];
  end

endmodule

//--- sim.f
logic/vid_geom_pkg.sv
logic/bmp_fmt_pkg.sv
logic/font_rom.sv
logic/image_rom.sv
logic/bmp_placer.sv
logic/video_mem.sv
logic/overlay_top.sv
bench/overlay_chk.sv
bench/overlay_tb.sv
